/* ntt_mult_defs.svh */
`ifndef NTT_MULT_DEFS_SVH
`define NTT_MULT_DEFS_SVH

// ------------------------------------------------------------
// Dilithium coefficient arithmetic
// ------------------------------------------------------------

// Coefficient width in bits
`define NTT_REG_SIZE 23

// Modulus q = 2^23 - 2^13 + 1
`define NTT_PRIME 8380417

// ------------------------------------------------------------
// Pipeline depth
// ------------------------------------------------------------

// Product register, fold adds, subtraction, output register
`define NTT_RED_LATENCY 4

// One extra cycle for the multiplier in front
`define NTT_MULT_LATENCY (`NTT_RED_LATENCY + 1)

`endif

/* ntt_mult_pkg.sv */
`include "ntt_mult_defs.svh"

package ntt_mult_pkg;

    // ------------------------------------------------------------
    // Coefficient and product types
    // ------------------------------------------------------------

    // Single coefficient, always below q
    typedef logic [`NTT_REG_SIZE-1:0] coeff_t;

    // Product split along the fold boundaries
    // Weights 2^43, 2^33, 2^23, 2^13 and 2^0
    typedef struct packed {
        logic [2:0]  top3;
        logic [9:0]  hi10;
        logic [9:0]  mid10;
        logic [9:0]  lo10;
        logic [12:0] low13;
    } prod_fields_t;

    // Same 46-bit product seen as raw word or as fold fields
    typedef union packed {
        logic [2*`NTT_REG_SIZE-1:0] raw;
        prod_fields_t               fields;
    } prod_word_u;

    // ------------------------------------------------------------
    // Reduction intermediates
    // ------------------------------------------------------------

    // Carry of the 10-bit field sum c and the refolded sum d
    typedef struct packed {
        logic [1:0]  carry;
        logic [10:0] d;
    } fold_sums_t;

    // Multiplier output beat
    typedef struct packed {
        logic       valid;
        prod_word_u word;
    } mult_beat_t;

endpackage

/* ntt_add_sub_mod.sv */
`timescale 1ns/1ns
`include "ntt_mult_defs.svh"

module ntt_add_sub_mod #(
    parameter int REG_SIZE = 23,
    parameter bit SUBTRACT = 1'b0
) (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                zeroize_i,
    input  logic                add_en_i,
    input  logic [REG_SIZE-1:0] opa_i,
    input  logic [REG_SIZE-1:0] opb_i,
    output logic [REG_SIZE-1:0] res_o,
    output logic                ready_o
);

    // Prime widened to the operand width
    localparam logic [REG_SIZE-1:0] PRIME = REG_SIZE'(`NTT_PRIME);

    logic [REG_SIZE-1:0] res_next;

    // ------------------------------------------------------------
    // Modular add or subtract, one correction step
    // ------------------------------------------------------------
    if (SUBTRACT) begin : g_sub
        // Extra bit holds the borrow
        logic [REG_SIZE:0] diff;

        assign diff = {1'b0, opa_i} - {1'b0, opb_i};
        // Negative difference wraps back up by q
        assign res_next = diff[REG_SIZE] ? (diff[REG_SIZE-1:0] + PRIME)
                                         : diff[REG_SIZE-1:0];
    end else begin : g_add
        logic [REG_SIZE:0] sum;
        logic [REG_SIZE:0] sum_red;

        assign sum     = {1'b0, opa_i} + {1'b0, opb_i};
        assign sum_red = sum - {1'b0, PRIME};
        // Borrow on sum - q means sum already in range
        assign res_next = sum_red[REG_SIZE] ? sum[REG_SIZE-1:0]
                                            : sum_red[REG_SIZE-1:0];
    end

    // ------------------------------------------------------------
    // Result register
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            res_o   <= '0;
            ready_o <= 1'b0;
        end else if (zeroize_i) begin
            res_o   <= '0;
            ready_o <= 1'b0;
        end else begin
            ready_o <= add_en_i;
            // Hold last result while idle
            if (add_en_i) begin
                res_o <= res_next;
            end
        end
    end

    // Operands below 2q must leave a fully reduced result
    a_res_in_range: assert property (
        @(posedge clk) disable iff (!reset_n)
        ready_o |-> (res_o < PRIME)
    ) else $error("add_sub_mod result %0d not below q", res_o);

endmodule

/* ntt_multiplier.sv */
`timescale 1ns/1ns
`include "ntt_mult_defs.svh"

module ntt_multiplier
    import ntt_mult_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    input  logic       zeroize_i,
    input  logic       valid_i,
    input  coeff_t     a_i,
    input  coeff_t     b_i,
    output mult_beat_t beat_o
);

    // Full-width product, never truncated
    logic [2*`NTT_REG_SIZE-1:0] prod;

    // ------------------------------------------------------------
    // 23x23 unsigned multiply
    // ------------------------------------------------------------

    // Zero-extend both sides so the multiply runs at 46 bits
    assign prod = {{`NTT_REG_SIZE{1'b0}}, a_i} * {{`NTT_REG_SIZE{1'b0}}, b_i};

    // ------------------------------------------------------------
    // Output register
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            beat_o <= '0;
        end else if (zeroize_i) begin
            // Drops the item in this stage
            beat_o <= '0;
        end else begin
            beat_o.valid <= valid_i;
            // Product only loaded with a live item
            if (valid_i) begin
                beat_o.word.raw <= prod;
            end
        end
    end

endmodule

/* ntt_fold_high.sv */
`timescale 1ns/1ns

module ntt_fold_high
    import ntt_mult_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    input  logic       zeroize_i,
    input  logic       en_i,
    input  prod_word_u word_i,
    input  fold_sums_t sums_i,
    output coeff_t     e_o,
    output logic       ready_o
);

    // Upper fold sum f, max 7 + 8191 + 3 fits 14 bits
    logic [13:0] f_sum;
    // Upper 23 product bits, weight 2^23
    coeff_t      z_hi;

    // ------------------------------------------------------------
    // Upper fold sum
    // ------------------------------------------------------------

    // 2^23 = 2^13 - 1 mod q, so the top fields come back at low weight
    // Terms: top3, {top3,hi10} and the carry out of c
    always_comb begin
        f_sum = 14'(word_i.fields.top3)
              + 14'({word_i.fields.top3, word_i.fields.hi10})
              + 14'(sums_i.carry);
    end

    // Raw view of the same word gives z[45:23] in one slice
    assign z_hi = word_i.raw[2*$bits(coeff_t)-1:$bits(coeff_t)];

    // ------------------------------------------------------------
    // e = (f + z[45:23]) mod q
    // ------------------------------------------------------------

    // Both operands below q here
    ntt_add_sub_mod #(
        .REG_SIZE (23),
        .SUBTRACT (1'b0)
    ) u_add_high (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .add_en_i  (en_i),
        .opa_i     ({9'd0, f_sum}),
        .opb_i     (z_hi),
        .res_o     (e_o),
        .ready_o   (ready_o)
    );

endmodule

/* ntt_fold_low.sv */
`timescale 1ns/1ns

module ntt_fold_low
    import ntt_mult_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic        zeroize_i,
    input  logic        en_i,
    input  fold_sums_t  sums_i,
    input  logic [12:0] low13_i,
    output coeff_t      g_o,
    output logic        ready_o
);

    // d << 13 may reach 1026 * 2^13, just over q
    logic [23:0] g_shift;
    // 24-bit adder result, always below q
    logic [23:0] g_res;

    // ------------------------------------------------------------
    // Low-weight residue
    // ------------------------------------------------------------

    // Place d at weight 2^13
    assign g_shift = {sums_i.d, 13'd0};

    // g = (d * 2^13 + z[12:0]) mod q
    // Sum stays below 2q so one correction is enough
    ntt_add_sub_mod #(
        .REG_SIZE (24),
        .SUBTRACT (1'b0)
    ) u_add_low (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .add_en_i  (en_i),
        .opa_i     (g_shift),
        .opb_i     ({11'd0, low13_i}),
        .res_o     (g_res),
        .ready_o   (ready_o)
    );

    // Top bit is zero once reduced
    assign g_o = coeff_t'(g_res);

endmodule

/* ntt_mult_reduction.sv */
`timescale 1ns/1ns
`include "ntt_mult_defs.svh"

module ntt_mult_reduction
    import ntt_mult_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    input  logic       zeroize_i,
    input  mult_beat_t beat_i,
    output coeff_t     res_o,
    output logic       valid_o
);

    // Registered product beat
    mult_beat_t beat_q;
    // Field sum c, max 7 + 3 * 1023 fits 12 bits
    logic [11:0] c_sum;
    fold_sums_t  sums;

    // Fold path results
    coeff_t e_val;
    coeff_t g_val;
    logic   ready_e;
    logic   ready_g;

    // Combining subtraction
    coeff_t sub_res;
    logic   sub_ready;

    // ------------------------------------------------------------
    // Stage 1, product register
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            beat_q <= '0;
        end else if (zeroize_i) begin
            beat_q <= '0;
        end else begin
            beat_q.valid <= beat_i.valid;
            if (beat_i.valid) begin
                beat_q.word <= beat_i.word;
            end
        end
    end

    // Carry sums c and d from the 10-bit fields
    always_comb begin
        c_sum = 12'(beat_q.word.fields.top3)
              + 12'(beat_q.word.fields.hi10)
              + 12'(beat_q.word.fields.mid10)
              + 12'(beat_q.word.fields.lo10);
        sums.carry = c_sum[11:10];
        // Carry at 2^10 folds back in at weight 1
        sums.d = 11'(c_sum[11:10]) + 11'(c_sum[9:0]);
    end

    // ------------------------------------------------------------
    // Stage 2, both fold paths side by side
    // ------------------------------------------------------------
    ntt_fold_high u_fold_high (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .en_i      (beat_q.valid),
        .word_i    (beat_q.word),
        .sums_i    (sums),
        .e_o       (e_val),
        .ready_o   (ready_e)
    );

    ntt_fold_low u_fold_low (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .en_i      (beat_q.valid),
        .sums_i    (sums),
        .low13_i   (beat_q.word.fields.low13),
        .g_o       (g_val),
        .ready_o   (ready_g)
    );

    // ------------------------------------------------------------
    // Stage 3, result = (g - e) mod q
    // ------------------------------------------------------------
    ntt_add_sub_mod #(
        .REG_SIZE (23),
        .SUBTRACT (1'b1)
    ) u_sub_comb (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .add_en_i  (ready_e & ready_g),
        .opa_i     (g_val),
        .opb_i     (e_val),
        .res_o     (sub_res),
        .ready_o   (sub_ready)
    );

    // ------------------------------------------------------------
    // Stage 4, output register
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            res_o   <= '0;
            valid_o <= 1'b0;
        end else if (zeroize_i) begin
            res_o   <= '0;
            valid_o <= 1'b0;
        end else begin
            valid_o <= sub_ready;
            if (sub_ready) begin
                res_o <= sub_res;
            end
        end
    end

    // Fold paths share one enable and depth, so they stay in step
    a_fold_lockstep: assert property (
        @(posedge clk) disable iff (!reset_n)
        ready_e == ready_g
    ) else $error("fold path ready strobes out of step");

    // A result is only produced from an edge with zeroize low
    a_no_valid_in_zeroize: assert property (
        @(posedge clk) disable iff (!reset_n)
        valid_o |-> !$past(zeroize_i)
    ) else $error("valid_o set while zeroize active");

    // Every result traces back to an input beat a fixed depth earlier
    a_red_latency: assert property (
        @(posedge clk) disable iff (!reset_n)
        valid_o |-> $past(beat_i.valid, `NTT_RED_LATENCY)
    ) else $error("valid_o without matching input beat");

endmodule

/* ntt_mod_mult.sv */
`timescale 1ns/1ns

module ntt_mod_mult
    import ntt_mult_pkg::*;
(
    input  logic   clk,
    input  logic   reset_n,
    input  logic   zeroize_i,
    input  logic   valid_i,
    input  coeff_t a_i,
    input  coeff_t b_i,
    output coeff_t res_o,
    output logic   valid_o
);

    // Multiplier to reduction beat
    mult_beat_t mult_beat;

    // ------------------------------------------------------------
    // Full product, 1 cycle
    // ------------------------------------------------------------
    ntt_multiplier u_multiplier (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .valid_i   (valid_i),
        .a_i       (a_i),
        .b_i       (b_i),
        .beat_o    (mult_beat)
    );

    // ------------------------------------------------------------
    // Reduction mod q, 4 cycles
    // ------------------------------------------------------------
    ntt_mult_reduction u_reduction (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .beat_i    (mult_beat),
        .res_o     (res_o),
        .valid_o   (valid_o)
    );

endmodule

/* ntt_mod_mult_checker.sv */
`timescale 1ns/1ns
`include "ntt_mult_defs.svh"

module ntt_mod_mult_checker
    import ntt_mult_pkg::*;
(
    input logic         clk,
    input logic         reset_n,
    input logic         zeroize_i,
    input logic         valid_i,
    input coeff_t       a_i,
    input coeff_t       b_i,
    input coeff_t       res_i,
    input logic         valid_out_i,
    input logic [127:0] name_i
);

    localparam longint unsigned Q = `NTT_PRIME;
    localparam int LAT = `NTT_MULT_LATENCY;

    // Pending items with the oldest at the front
    logic [127:0] name_q[$];
    coeff_t       exp_q[$];
    int           issue_q[$];

    // Inputs captured on the rising edge for the falling edge compare
    int           cyc = 0;
    // Cycle in which the captured inputs were presented
    int           cap_cyc = 0;
    logic         cap_zero = 1'b1;
    logic         cap_valid = 1'b0;
    coeff_t       cap_a = '0;
    coeff_t       cap_b = '0;
    logic [127:0] cap_name = '0;

    // Popped item
    logic [127:0] pop_name;
    coeff_t       pop_exp;
    int           pop_issue;

    // Error counts summed by the testbench top
    int value_errors = 0;
    int latency_errors = 0;
    int unexpected_errors = 0;
    int missing_errors = 0;
    int zero_errors = 0;
    int pending = 0;

    // Plain 64-bit product then remainder by q
    function automatic coeff_t mod_product(input coeff_t a, input coeff_t b);
        longint unsigned p;
        p = 64'(a) * 64'(b);
        return coeff_t'(p % Q);
    endfunction

    // ------------------------------------------------------------
    // Input capture once per cycle
    // ------------------------------------------------------------
    always @(posedge clk) begin
        cyc       <= cyc + 1;
        cap_cyc   <= cyc;
        cap_zero  <= !reset_n || zeroize_i;
        cap_valid <= valid_i;
        cap_a     <= a_i;
        cap_b     <= b_i;
        cap_name  <= name_i;
    end

    // ------------------------------------------------------------
    // Output compare on the falling edge
    // ------------------------------------------------------------
    always @(negedge clk) begin
        if (cap_zero) begin
            // Everything in flight is dropped
            name_q.delete();
            exp_q.delete();
            issue_q.delete();
            if (valid_out_i !== 1'b0 || res_i !== '0) begin
                zero_errors++;
                $display("Outputs not cleared at cycle %0d: valid_o=%b res_o=%0d",
                         cyc, valid_out_i, res_i);
            end
        end else begin
            if (valid_out_i === 1'b1) begin
                if (exp_q.size() == 0) begin
                    unexpected_errors++;
                    $display("valid_o high at cycle %0d with no item pending", cyc);
                end else begin
                    pop_name  = name_q.pop_front();
                    pop_exp   = exp_q.pop_front();
                    pop_issue = issue_q.pop_front();
                    if (cyc - pop_issue != LAT) begin
                        latency_errors++;
                        $display("Wrong latency for %s: %0d cycles instead of %0d",
                                 pop_name, cyc - pop_issue, LAT);
                    end
                    if (res_i !== pop_exp) begin
                        value_errors++;
                        $display("FAIL %s: expected %0d, actual %0d", pop_name, pop_exp, res_i);
                    end
                end
            end else if (valid_out_i !== 1'b0) begin
                unexpected_errors++;
                $display("valid_o is unknown at cycle %0d", cyc);
            end
            // Oldest item overdue so its result never came
            if (issue_q.size() > 0 && cyc - issue_q[0] > LAT) begin
                missing_errors++;
                $display("No result for %s issued at cycle %0d", name_q[0], issue_q[0]);
                void'(name_q.pop_front());
                void'(exp_q.pop_front());
                void'(issue_q.pop_front());
            end
            if (cap_valid) begin
                name_q.push_back(cap_name);
                exp_q.push_back(mod_product(cap_a, cap_b));
                issue_q.push_back(cap_cyc);
            end
        end
        pending = exp_q.size();
    end

endmodule

/* tb_ntt_mod_mult.sv */
`timescale 1ns/1ns
`include "ntt_mult_defs.svh"

module tb_ntt_mod_mult
    import ntt_mult_pkg::*;
();

    localparam int CLK_PERIOD = 10;
    localparam int NUM_RANDOM = 64;
    localparam int NUM_STIM   = 17;

    // One stimulus row
    typedef struct packed {
        logic [127:0] name;
        coeff_t       a;
        coeff_t       b;
        logic         zeroize;
        logic [3:0]   gap;
    } stim_t;

    // ------------------------------------------------------------
    // Stimulus table: name, a, b, zeroize, idle cycles after
    // ------------------------------------------------------------
    localparam stim_t STIM_TAB [NUM_STIM] = '{
        '{"zero_times_x",   23'd0,       23'd5555,    1'b0, 4'd0},
        '{"x_times_zero",   23'd1234567, 23'd0,       1'b0, 4'd0},
        '{"one_times_max",  23'd1,       23'd8380416, 1'b0, 4'd0},
        '{"max_times_one",  23'd7654321, 23'd1,       1'b0, 4'd0},
        '{"max_squared",    23'd8380416, 23'd8380416, 1'b0, 4'd0},
        '{"max_times_two",  23'd8380416, 23'd2,       1'b0, 4'd3},
        // Single bit at 2^44, lands in top3 only
        '{"pow2_44",        23'd4194304, 23'd4194304, 1'b0, 4'd0},
        // low13 all zero
        '{"low13_zero",     23'd8192000, 23'd8192,    1'b0, 4'd0},
        // low13 equal to one
        '{"low13_one",      23'd8192001, 23'd8193,    1'b0, 4'd0},
        '{"qm2_squared",    23'd8380415, 23'd8380415, 1'b0, 4'd0},
        // top3 all ones, upper hi10 bits set
        '{"hi_fields_ones", 23'd8380416, 23'd8380400, 1'b0, 4'd2},
        // Three items in flight, then dropped by zeroize
        '{"inflight_a",     23'd3000001, 23'd4000003, 1'b0, 4'd0},
        '{"inflight_b",     23'd5000011, 23'd6000007, 1'b0, 4'd0},
        '{"inflight_c",     23'd7000003, 23'd2000029, 1'b0, 4'd0},
        '{"zeroize_drop",   23'd1111111, 23'd2222222, 1'b1, 4'd0},
        '{"after_zeroize",  23'd3333333, 23'd4444444, 1'b0, 4'd0},
        '{"after_zeroize2", 23'd8380416, 23'd8380416, 1'b0, 4'd6}
    };

    logic         clk;
    logic         reset_n;
    logic         zeroize_i;
    logic         valid_i;
    coeff_t       a_i;
    coeff_t       b_i;
    coeff_t       res_o;
    logic         valid_o;
    logic [127:0] test_name;
    logic [31:0]  rng_state;

    // 32-bit xorshift step
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Present one item for a single cycle
    task automatic drive_item(input logic [127:0] name, input coeff_t a, input coeff_t b,
                              input logic zero);
        test_name = name;
        a_i       = a;
        b_i       = b;
        zeroize_i = zero;
        valid_i   = 1'b1;
    endtask

    task automatic drive_idle();
        valid_i   = 1'b0;
        zeroize_i = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ntt_mod_mult dut_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .valid_i   (valid_i),
        .a_i       (a_i),
        .b_i       (b_i),
        .res_o     (res_o),
        .valid_o   (valid_o)
    );

    ntt_mod_mult_checker chk_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize_i   (zeroize_i),
        .valid_i     (valid_i),
        .a_i         (a_i),
        .b_i         (b_i),
        .res_i       (res_o),
        .valid_out_i (valid_o),
        .name_i      (test_name)
    );

    // ------------------------------------------------------------
    // Stimulus, all inputs change on the falling edge
    // ------------------------------------------------------------
    initial begin : stimulus
        int total;
        reset_n   = 1'b0;
        zeroize_i = 1'b0;
        valid_i   = 1'b0;
        a_i       = '0;
        b_i       = '0;
        test_name = '0;
        rng_state = 32'd38;
        repeat (2) @(negedge clk);
        reset_n = 1'b1;

        // Directed rows
        for (int i = 0; i < NUM_STIM; i++) begin
            @(negedge clk);
            drive_item(STIM_TAB[i].name, STIM_TAB[i].a, STIM_TAB[i].b, STIM_TAB[i].zeroize);
            for (int g = 0; g < int'(STIM_TAB[i].gap); g++) begin
                @(negedge clk);
                drive_idle();
            end
        end

        // Random pairs back to back, five in flight
        for (int i = 0; i < NUM_RANDOM; i++) begin
            @(negedge clk);
            rng_state = xorshift32(rng_state);
            a_i       = coeff_t'(rng_state % `NTT_PRIME);
            rng_state = xorshift32(rng_state);
            b_i       = coeff_t'(rng_state % `NTT_PRIME);
            test_name = "random";
            zeroize_i = 1'b0;
            valid_i   = 1'b1;
        end
        @(negedge clk);
        drive_idle();

        // Drain, then watch a few idle cycles
        wait (chk_i.pending == 0);
        repeat (4) @(negedge clk);

        total = chk_i.value_errors + chk_i.latency_errors + chk_i.unexpected_errors
              + chk_i.missing_errors + chk_i.zero_errors + chk_i.pending;
        $display("Errors: %0d value, %0d latency, %0d unexpected, %0d missing, %0d not cleared, %0d pending",
                 chk_i.value_errors, chk_i.latency_errors, chk_i.unexpected_errors,
                 chk_i.missing_errors, chk_i.zero_errors, chk_i.pending);
        if (total == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // ------------------------------------------------------------
    // Watchdog, rows plus gaps plus random pairs plus drain margin
    // ------------------------------------------------------------
    initial begin : watchdog
        int cycles;
        cycles = NUM_STIM + NUM_RANDOM + `NTT_MULT_LATENCY + 20;
        for (int i = 0; i < NUM_STIM; i++) begin
            cycles = cycles + int'(STIM_TAB[i].gap);
        end
        #(cycles * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles", cycles);
        $display("Something failed");
        $finish;
    end

endmodule

/* compile.f */
+incdir+.
ntt_mult_pkg.sv
ntt_add_sub_mod.sv
ntt_multiplier.sv
ntt_fold_high.sv
ntt_fold_low.sv
ntt_mult_reduction.sv
ntt_mod_mult.sv
ntt_mod_mult_checker.sv
tb_ntt_mod_mult.sv

/* Makefile */
# Verilator build for the NTT modular multiplier

VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_ntt_mod_mult
RTL_TOP   ?= ntt_mod_mult
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) *.sv *.svh
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# Pass only when the pass line shows up in the output
sim: $(OBJ_DIR)/V$(TOP)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf $(OBJ_DIR)
